//--- verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW = 10;
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {OP_A_REG, OP_A_PC} op_a_sel_e;
    typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP} pc_sel_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_FETCH_DONE,
        S_EXEC,
        S_MEM,
        S_MEM_DONE,
        S_HALT
    } core_state_e;

    typedef struct packed {
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        wb_sel_e   wb_sel;
        pc_sel_e   pc_sel;
        logic      br_kind;    // 0 for BEQ, 1 for BNE
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
        logic      is_ebreak;
    } ctrl_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  wire                    clk,
    input  wire                    we_i,
    input  wire rv_core_pkg::reg_idx_t waddr_i,
    input  wire rv_core_pkg::word_t    wdata_i,
    input  wire rv_core_pkg::reg_idx_t raddr1_i,
    input  wire rv_core_pkg::reg_idx_t raddr2_i,
    output rv_core_pkg::word_t         rdata1_o,
    output rv_core_pkg::word_t         rdata2_o
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 always reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- verilog/rv_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
    input  wire rv_core_pkg::inst_t inst_i,
    output rv_core_pkg::reg_idx_t   rs1_o,
    output rv_core_pkg::reg_idx_t   rs2_o,
    output rv_core_pkg::reg_idx_t   rd_o,
    output rv_core_pkg::word_t      imm_o,
    output rv_core_pkg::ctrl_t      ctrl_o
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o = inst_i[11:7];

    // Immediate format follows the opcode
    always_comb begin
        case (opcode)
            OPC_STORE:  imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            OPC_BRANCH: imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                                 inst_i[30:25], inst_i[11:8], 1'b0};
            OPC_LUI:    imm_o = {inst_i[31:12], 12'b0};
            OPC_JAL:    imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                                 inst_i[20], inst_i[30:21], 1'b0};
            default:    imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
        endcase
    end

    always_comb begin
        // All-zero struct is a NOP that falls through to PC plus 4
        ctrl_o = '0;
        case (opcode)
            OPC_OP: begin
                ctrl_o.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    default:              ctrl_o.reg_we = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                // ADDI only
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.reg_we = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                ctrl_o.alu_op = ALU_PASS_B;
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_LOAD: begin
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.wb_sel = WB_MEM;
                ctrl_o.reg_we = (funct3 == 3'b010);
                ctrl_o.mem_re = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.mem_we = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                if (funct3[2:1] == 2'b00) begin
                    ctrl_o.pc_sel = PC_BRANCH;
                    ctrl_o.br_kind = funct3[0];
                end
            end
            OPC_JAL: begin
                // ALU forms the target, rd takes PC plus 4
                ctrl_o.op_a_sel = OP_A_PC;
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.wb_sel = WB_PC4;
                ctrl_o.pc_sel = PC_JUMP;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_SYSTEM: begin
                ctrl_o.is_ebreak = (inst_i == 32'h0010_0073);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/rv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
    input  wire rv_core_pkg::alu_op_e op_i,
    input  wire rv_core_pkg::word_t   a_i,
    input  wire rv_core_pkg::word_t   b_i,
    output rv_core_pkg::word_t        result_o,
    input  wire                       br_kind_i,
    input  wire                       is_branch_i,
    output logic                      taken_o
);
    import rv_core_pkg::*;

    logic equal;

    always_comb begin
        case (op_i)
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_PASS_B: result_o = b_i;
            default:    result_o = a_i + b_i;
        endcase
    end

    // BNE inverts the equality test
    assign equal = (a_i == b_i);
    assign taken_o = is_branch_i && (equal ^ br_kind_i);

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     run_i,
    output logic                    halted_o,
    output logic                    ifetch_req_o,
    output rv_core_pkg::mem_req_t   ifetch_o,
    input  wire                     ifetch_ack_i,
    input  wire rv_core_pkg::mem_rsp_t ifetch_rsp_i,
    output logic                    data_req_o,
    output rv_core_pkg::mem_req_t   data_o,
    input  wire                     data_ack_i,
    input  wire rv_core_pkg::mem_rsp_t data_rsp_i
);
    import rv_core_pkg::*;

    core_state_e state_q;
    addr_t pc_q;
    inst_t ir_q;
    word_t load_q;

    reg_idx_t rs1, rs2, rd;
    word_t imm, rdata1, rdata2;
    word_t op_a, op_b, alu_result, wb_data;
    ctrl_t ctrl;
    logic taken;
    logic is_mem;
    logic commit;
    addr_t pc_plus4, br_target, pc_next;

    rv_decoder u_decoder (
        .inst_i(ir_q),
        .rs1_o(rs1),
        .rs2_o(rs2),
        .rd_o(rd),
        .imm_o(imm),
        .ctrl_o(ctrl)
    );

    rv_regfile u_regfile (
        .clk(clk),
        .we_i(commit && ctrl.reg_we),
        .waddr_i(rd),
        .wdata_i(wb_data),
        .raddr1_i(rs1),
        .raddr2_i(rs2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    assign op_a = (ctrl.op_a_sel == OP_A_PC) ? pc_q : rdata1;
    assign op_b = (ctrl.op_b_sel == OP_B_IMM) ? imm : rdata2;

    rv_alu u_alu (
        .op_i(ctrl.alu_op),
        .a_i(op_a),
        .b_i(op_b),
        .result_o(alu_result),
        .br_kind_i(ctrl.br_kind),
        .is_branch_i(ctrl.pc_sel == PC_BRANCH),
        .taken_o(taken)
    );

    assign pc_plus4 = pc_q + 32'd4;
    assign br_target = pc_q + imm;

    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: pc_next = taken ? br_target : pc_plus4;
            PC_JUMP:   pc_next = alu_result;
            default:   pc_next = pc_plus4;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = load_q;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // Instruction retires at end of EXEC, or once the data ack is gone
    assign is_mem = ctrl.mem_re || ctrl.mem_we;
    assign commit = ((state_q == S_EXEC) && !ctrl.is_ebreak && !is_mem) ||
                    ((state_q == S_MEM_DONE) && !data_ack_i);

    // Both masters hold req for the whole request phase of their state
    assign ifetch_req_o = (state_q == S_FETCH);
    assign ifetch_o = '{addr: pc_q, wdata: '0, we: 1'b0};
    assign data_req_o = (state_q == S_MEM);
    assign data_o = '{addr: alu_result, wdata: rdata2, we: ctrl.mem_we};
    assign halted_o = (state_q == S_HALT);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            pc_q <= RESET_PC;
        end else begin
            case (state_q)
                S_IDLE:       if (run_i) state_q <= S_FETCH;
                S_FETCH:      if (ifetch_ack_i) state_q <= S_FETCH_DONE;
                S_FETCH_DONE: if (!ifetch_ack_i) state_q <= S_EXEC;
                S_EXEC: begin
                    if (ctrl.is_ebreak) begin
                        state_q <= S_HALT;
                    end else if (is_mem) begin
                        state_q <= S_MEM;
                    end else begin
                        state_q <= S_FETCH;
                    end
                end
                S_MEM:        if (data_ack_i) state_q <= S_MEM_DONE;
                S_MEM_DONE:   if (!data_ack_i) state_q <= S_FETCH;
                S_HALT:       state_q <= S_HALT;
                default:      state_q <= S_IDLE;
            endcase
            if (commit) begin
                pc_q <= pc_next;
            end
        end
    end

    // Capture rdata while ack is high
    always_ff @(posedge clk) begin
        if ((state_q == S_FETCH) && ifetch_ack_i) begin
            ir_q <= ifetch_rsp_i.rdata;
        end
        if ((state_q == S_MEM) && data_ack_i) begin
            load_q <= data_rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        host_req_i,
    input  wire rv_core_pkg::mem_req_t host_i,
    output logic                       host_ack_o,
    output rv_core_pkg::mem_rsp_t      host_rsp_o,
    input  wire                        data_req_i,
    input  wire rv_core_pkg::mem_req_t data_i,
    output logic                       data_ack_o,
    output rv_core_pkg::mem_rsp_t      data_rsp_o,
    input  wire                        fetch_req_i,
    input  wire rv_core_pkg::mem_req_t fetch_i,
    output logic                       fetch_ack_o,
    output rv_core_pkg::mem_rsp_t      fetch_rsp_o,
    output logic                       ram_req_o,
    output rv_core_pkg::mem_req_t      ram_o,
    input  wire                        ram_ack_i,
    input  wire rv_core_pkg::mem_rsp_t ram_rsp_i
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {GNT_IDLE, GNT_HOST, GNT_DATA, GNT_FETCH} grant_e;

    grant_e owner_q;

    // Only the owner sees ack and rdata
    always_comb begin
        ram_req_o = 1'b0;
        ram_o = '0;
        host_ack_o = 1'b0;
        data_ack_o = 1'b0;
        fetch_ack_o = 1'b0;
        host_rsp_o = '0;
        data_rsp_o = '0;
        fetch_rsp_o = '0;
        case (owner_q)
            GNT_HOST: begin
                ram_req_o = host_req_i;
                ram_o = host_i;
                host_ack_o = ram_ack_i;
                host_rsp_o = ram_rsp_i;
            end
            GNT_DATA: begin
                ram_req_o = data_req_i;
                ram_o = data_i;
                data_ack_o = ram_ack_i;
                data_rsp_o = ram_rsp_i;
            end
            GNT_FETCH: begin
                ram_req_o = fetch_req_i;
                ram_o = fetch_i;
                fetch_ack_o = ram_ack_i;
                fetch_rsp_o = ram_rsp_i;
            end
            default: ;
        endcase
    end

    // Fixed priority host, data, fetch; release after both req and ack fall
    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner_q <= GNT_IDLE;
        end else if (owner_q == GNT_IDLE) begin
            if (host_req_i) begin
                owner_q <= GNT_HOST;
            end else if (data_req_i) begin
                owner_q <= GNT_DATA;
            end else if (fetch_req_i) begin
                owner_q <= GNT_FETCH;
            end
        end else if (!ram_req_o && !ram_ack_i) begin
            owner_q <= GNT_IDLE;
        end
    end

endmodule

`default_nettype wire

//--- verilog/shared_ram.sv
`timescale 1ns/100ps
`default_nettype none

module shared_ram (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        req_i,
    input  wire rv_core_pkg::mem_req_t req_bus_i,
    output logic                       ack_o,
    output rv_core_pkg::mem_rsp_t      rsp_o
);
    import rv_core_pkg::*;

    word_t mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;
    logic start;

    // Word index from the byte address
    assign idx = req_bus_i.addr[RAM_AW+1:2];
    assign start = req_i && !ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else if (start) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (req_bus_i.we) begin
                mem[idx] <= req_bus_i.wdata;
            end
            rsp_o.rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_system.sv
`timescale 1ns/100ps
`default_nettype none

module rv_system (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        run_i,
    output logic                       halted_o,
    input  wire                        host_req_i,
    input  wire rv_core_pkg::mem_req_t host_i,
    output logic                       host_ack_o,
    output rv_core_pkg::mem_rsp_t      host_rsp_o
);
    import rv_core_pkg::*;

    logic ifetch_req, ifetch_ack;
    mem_req_t ifetch_bus;
    mem_rsp_t ifetch_rsp;

    logic data_req, data_ack;
    mem_req_t data_bus;
    mem_rsp_t data_rsp;

    logic ram_req, ram_ack;
    mem_req_t ram_bus;
    mem_rsp_t ram_rsp;

    rv_core u_core (
        .clk(clk),
        .reset_i(reset_i),
        .run_i(run_i),
        .halted_o(halted_o),
        .ifetch_req_o(ifetch_req),
        .ifetch_o(ifetch_bus),
        .ifetch_ack_i(ifetch_ack),
        .ifetch_rsp_i(ifetch_rsp),
        .data_req_o(data_req),
        .data_o(data_bus),
        .data_ack_i(data_ack),
        .data_rsp_i(data_rsp)
    );

    // Host outranks the core's data port, which outranks fetch
    mem_arbiter u_arbiter (
        .clk(clk),
        .reset_i(reset_i),
        .host_req_i(host_req_i),
        .host_i(host_i),
        .host_ack_o(host_ack_o),
        .host_rsp_o(host_rsp_o),
        .data_req_i(data_req),
        .data_i(data_bus),
        .data_ack_o(data_ack),
        .data_rsp_o(data_rsp),
        .fetch_req_i(ifetch_req),
        .fetch_i(ifetch_bus),
        .fetch_ack_o(ifetch_ack),
        .fetch_rsp_o(ifetch_rsp),
        .ram_req_o(ram_req),
        .ram_o(ram_bus),
        .ram_ack_i(ram_ack),
        .ram_rsp_i(ram_rsp)
    );

    shared_ram u_ram (
        .clk(clk),
        .reset_i(reset_i),
        .req_i(ram_req),
        .req_bus_i(ram_bus),
        .ack_o(ram_ack),
        .rsp_o(ram_rsp)
    );

endmodule

`default_nettype wire

//--- test/tb_rv_system.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_system;
    import rv_core_pkg::*;

    // About 300 instructions at under 20 cycles each, plus host traffic
    localparam int CYCLE_LIMIT = 20000;

    logic clk;
    logic reset;
    logic run;
    logic halted;
    logic host_req;
    mem_req_t host_bus;
    logic host_ack;
    mem_rsp_t host_rsp;

    int cycle_count;
    int check_count;
    int error_count;
    inst_t prog [$];

    rv_system UUT (
        .clk(clk),
        .reset_i(reset),
        .run_i(run),
        .halted_o(halted),
        .host_req_i(host_req),
        .host_i(host_bus),
        .host_ack_o(host_ack),
        .host_rsp_o(host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Instruction formats
    function automatic inst_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Assembler helpers, registers and immediates passed as plain integers
    function automatic inst_t addi_insn(input int rd, input int rs1, input int imm);
        return i_type(imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OPIMM);
    endfunction

    function automatic inst_t add_insn(input int rd, input int rs1, input int rs2);
        return r_type(7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0]);
    endfunction

    function automatic inst_t sub_insn(input int rd, input int rs1, input int rs2);
        return r_type(7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0]);
    endfunction

    function automatic inst_t and_insn(input int rd, input int rs1, input int rs2);
        return r_type(7'b0000000, rs2[4:0], rs1[4:0], 3'b111, rd[4:0]);
    endfunction

    function automatic inst_t or_insn(input int rd, input int rs1, input int rs2);
        return r_type(7'b0000000, rs2[4:0], rs1[4:0], 3'b110, rd[4:0]);
    endfunction

    function automatic inst_t xor_insn(input int rd, input int rs1, input int rs2);
        return r_type(7'b0000000, rs2[4:0], rs1[4:0], 3'b100, rd[4:0]);
    endfunction

    function automatic inst_t slt_insn(input int rd, input int rs1, input int rs2);
        return r_type(7'b0000000, rs2[4:0], rs1[4:0], 3'b010, rd[4:0]);
    endfunction

    function automatic inst_t lui_insn(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic inst_t lw_insn(input int rd, input int rs1, input int off);
        return i_type(off[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD);
    endfunction

    function automatic inst_t sw_insn(input int rs2, input int rs1, input int off);
        return s_type(off[11:0], rs2[4:0], rs1[4:0]);
    endfunction

    function automatic inst_t bne_insn(input int rs1, input int rs2, input int off);
        return b_type(off[12:0], rs2[4:0], rs1[4:0], 3'b001);
    endfunction

    function automatic inst_t jal_insn(input int rd, input int off);
        return j_type(off[20:0], rd[4:0]);
    endfunction

    function automatic inst_t ebreak_insn();
        return {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};
    endfunction

    task automatic emit(input inst_t insn);
        prog.push_back(insn);
    endtask

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task automatic emit_li(input int rd, input word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        emit(lui_insn(rd, upper));
        emit(addi_insn(rd, rd, int'(value[11:0])));
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s read %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        run = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // One four-phase transfer on the host port
    task automatic host_transfer(input addr_t addr, input word_t wdata, input logic we,
                                 output word_t rdata);
        @(posedge clk);
        #1;
        host_req = 1'b1;
        host_bus = '{addr: addr, wdata: wdata, we: we};
        do begin
            @(posedge clk);
            #1;
        end while (!host_ack);
        rdata = host_rsp.rdata;
        host_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (host_ack);
    endtask

    task automatic host_write(input addr_t addr, input word_t data);
        word_t unused;
        host_transfer(addr, data, 1'b1, unused);
    endtask

    task automatic host_read(input addr_t addr, output word_t data);
        host_transfer(addr, '0, 1'b0, data);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            host_write(RESET_PC + 4 * i, prog[i]);
        end
    endtask

    // Core must stay halted once run is withdrawn
    task automatic run_until_halt();
        @(posedge clk);
        #1;
        run = 1'b1;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        run = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        check_flag(halted, 1'b1, "halted held after run drops");
    endtask

    // Sum 1..n with BNE, JAL over a poisoned store, then marker and link
    task automatic build_loop_program(input int n, input int base);
        prog.delete();
        emit(addi_insn(10, 0, base));
        emit(addi_insn(1, 0, 0));
        emit(addi_insn(2, 0, 0));
        emit(addi_insn(3, 0, n));
        emit(addi_insn(2, 2, 1));
        emit(add_insn(1, 1, 2));
        emit(bne_insn(2, 3, -8));
        emit(sw_insn(1, 10, 0));
        emit(jal_insn(5, 8));
        emit(sw_insn(3, 10, 4));
        emit(addi_insn(4, 0, 'h5a));
        emit(sw_insn(4, 10, 8));
        emit(sw_insn(5, 10, 12));
        emit(ebreak_insn());
    endtask

    task automatic check_loop_results(input int n, input int base, input word_t old);
        word_t got;
        host_read(base, got);
        check_word(got, n * (n + 1) / 2, "loop sum");
        host_read(base + 4, got);
        check_word(got, old, "skipped store location");
        host_read(base + 8, got);
        check_word(got, 32'h5a, "loop marker");
        // JAL sits at word 8
        host_read(base + 12, got);
        check_word(got, 32'd36, "JAL link");
    endtask

    task automatic host_test();
        addr_t addrs [8];
        word_t vals [8];
        word_t rnd;
        word_t got;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom;
            addrs[i] = 32'h400 + 64 * i + 4 * (rnd % 16);
            vals[i] = $urandom;
            host_write(addrs[i], vals[i]);
        end
        for (int i = 7; i >= 0; i--) begin
            host_read(addrs[i], got);
            check_word(got, vals[i], $sformatf("host readback %0d", i));
        end
    endtask

    task automatic arith_test();
        word_t a;
        word_t b;
        word_t rnd;
        word_t got;
        word_t expected [8];
        logic [11:0] imm12;
        logic [19:0] u20;
        // Signs differ so that signed and unsigned SLT disagree
        a = $urandom | 32'h8000_0000;
        b = $urandom & 32'h7fff_ffff;
        rnd = $urandom;
        imm12 = rnd[11:0];
        u20 = rnd[31:12];
        expected[0] = a + {{20{imm12[11]}}, imm12};
        expected[1] = a + b;
        expected[2] = a - b;
        expected[3] = a & b;
        expected[4] = a | b;
        expected[5] = a ^ b;
        expected[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        expected[7] = {u20, 12'h000};
        prog.delete();
        emit(addi_insn(10, 0, 'h600));
        emit_li(1, a);
        emit_li(2, b);
        emit(addi_insn(3, 1, int'(imm12)));
        emit(add_insn(4, 1, 2));
        emit(sub_insn(5, 1, 2));
        emit(and_insn(6, 1, 2));
        emit(or_insn(7, 1, 2));
        emit(xor_insn(8, 1, 2));
        emit(slt_insn(9, 1, 2));
        emit(lui_insn(11, int'(u20)));
        for (int i = 0; i < 7; i++) begin
            emit(sw_insn(3 + i, 10, 4 * i));
        end
        emit(sw_insn(11, 10, 28));
        emit(ebreak_insn());
        apply_reset();
        check_flag(halted, 1'b0, "halted after reset");
        load_program();
        run_until_halt();
        for (int i = 0; i < 8; i++) begin
            host_read(32'h600 + 4 * i, got);
            check_word(got, expected[i], $sformatf("arith result %0d", i));
        end
    endtask

    task automatic loop_test();
        int n;
        n = 5 + ($urandom % 16);
        build_loop_program(n, 'h680);
        apply_reset();
        check_flag(halted, 1'b0, "halted after reset");
        host_write(32'h684, 32'hdead_beef);
        load_program();
        run_until_halt();
        check_loop_results(n, 'h680, 32'hdead_beef);
    endtask

    task automatic load_store_test();
        word_t w1;
        word_t w2;
        word_t got;
        w1 = $urandom;
        w2 = $urandom;
        prog.delete();
        emit(addi_insn(10, 0, 'h700));
        emit(lw_insn(1, 10, 0));
        emit(lw_insn(2, 10, 4));
        emit(add_insn(3, 1, 2));
        emit(sub_insn(4, 1, 2));
        emit(sw_insn(3, 10, 8));
        emit(sw_insn(4, 10, 12));
        emit(ebreak_insn());
        apply_reset();
        host_write(32'h700, w1);
        host_write(32'h704, w2);
        load_program();
        run_until_halt();
        host_read(32'h708, got);
        check_word(got, w1 + w2, "loaded sum");
        host_read(32'h70c, got);
        check_word(got, w1 - w2, "loaded difference");
    endtask

    task automatic zero_reg_test();
        word_t got;
        prog.delete();
        emit(addi_insn(10, 0, 'h720));
        emit(addi_insn(0, 0, 'h123));
        emit(sw_insn(0, 10, 0));
        emit(addi_insn(1, 0, 'h11));
        emit(add_insn(0, 1, 1));
        emit(sw_insn(0, 10, 4));
        emit(ebreak_insn());
        apply_reset();
        // Nonzero old contents so a zero store is visible
        host_write(32'h720, $urandom | 32'h1);
        host_write(32'h724, $urandom | 32'h1);
        load_program();
        run_until_halt();
        host_read(32'h720, got);
        check_word(got, 32'h0, "x0 after ADDI");
        host_read(32'h724, got);
        check_word(got, 32'h0, "x0 after ADD");
    endtask

    task automatic contention_test();
        word_t host_vals [16];
        int n;
        n = 5 + ($urandom % 16);
        build_loop_program(n, 'h6c0);
        apply_reset();
        host_write(32'h6c4, 32'h0bad_f00d);
        for (int i = 0; i < 16; i++) begin
            host_vals[i] = $urandom;
            host_write(32'ha00 + 4 * i, host_vals[i]);
        end
        load_program();
        fork
            run_until_halt();
            begin
                word_t got;
                for (int i = 0; i < 16; i++) begin
                    repeat ($urandom % 4) @(posedge clk);
                    host_read(32'ha00 + 4 * i, got);
                    check_word(got, host_vals[i], $sformatf("host read under load %0d", i));
                end
            end
        join
        check_loop_results(n, 'h6c0, 32'h0bad_f00d);
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        host_req = 1'b0;
        host_bus = '0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        void'($urandom(32'h13310dd5));
        host_test();
        arith_test();
        loop_test();
        load_store_test();
        zero_reg_test();
        contention_test();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/rv_core_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_core.sv
verilog/mem_arbiter.sv
verilog/shared_ram.sv
verilog/rv_system.sv
test/tb_rv_system.sv

//--- Makefile
TOP = tb_rv_system

.PHONY: all lint clean

all:
	verilator --binary --timescale 1ns/100ps -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
